// ==== logic/memPkg.sv ====
`default_nettype none

package memPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Data path widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [31:0] wordT;                 // Data word or virtual address.
    typedef logic [3:0]  strobeT;               // One bit per byte lane.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        sizeByte = 2'd0,
        sizeHalf = 2'd1,
        sizeWord = 2'd2
    } msizeT;

    // Address errors only; other causes are raised upstream.
    typedef enum logic [1:0] {
        excNone = 2'd0,
        excAdEL = 2'd1,
        excAdES = 2'd2
    } excCodeT;

    typedef enum logic [1:0] {
        busIdle  = 2'd0,
        busLane1 = 2'd1,                        // Older access on the bus.
        busLane0 = 2'd2,
        busDone  = 2'd3
    } busStateT;

endpackage

`default_nettype wire

// ==== logic/storeAlign.sv ====
`timescale 1ns/1ps
`default_nettype none

module storeAlign import memPkg::*; (
    input  msizeT      size,
    input  logic [1:0] addrLow,
    input  wordT       storeData,
    output wordT       laneData,
    output strobeT     sel,
    output logic       misaligned
);

    always_comb begin
        laneData   = storeData;
        sel        = '0;
        misaligned = 1'b0;
        case (size)
            sizeByte: begin
                laneData = {4{storeData[7:0]}};     // Every lane carries the byte.
                sel      = strobeT'(4'b0001 << addrLow);
            end
            sizeHalf: begin
                laneData = {2{storeData[15:0]}};
                if (addrLow[0]) begin
                    misaligned = 1'b1;
                end else begin
                    sel = addrLow[1] ? 4'b1100 : 4'b0011;
                end
            end
            sizeWord: begin
                if (addrLow != 2'b00) begin
                    misaligned = 1'b1;
                end else begin
                    sel = 4'b1111;
                end
            end
            default: begin
                sel = '0;                           // Unused size code selects nothing.
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/loadExtend.sv ====
`timescale 1ns/1ps
`default_nettype none

module loadExtend import memPkg::*; (
    input  msizeT      size,
    input  logic [1:0] addrLow,
    input  logic       signExt,
    input  wordT       readWord,
    output wordT       loadValue
);

    wordT shifted;

    // Bring the addressed byte lane down to bit 0.
    assign shifted = readWord >> {addrLow, 3'b000};

    always_comb begin
        case (size)
            sizeByte: begin
                loadValue = {{24{signExt & shifted[7]}}, shifted[7:0]};
            end
            sizeHalf: begin
                loadValue = {{16{signExt & shifted[15]}}, shifted[15:0]};
            end
            default: begin
                loadValue = readWord;               // Word loads are aligned already.
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/memStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module memStage import memPkg::*; #(
    parameter int AdrWidth = 29
) (
    input  logic                laneValid0,
    input  logic                isLoad0,
    input  logic                isStore0,
    input  msizeT               size0,
    input  wordT                vaddr0,
    input  wordT                storeData0,
    input  logic                excIn0,
    input  logic                laneValid1,
    input  logic                isLoad1,
    input  logic                isStore1,
    input  msizeT               size1,
    input  wordT                vaddr1,
    input  wordT                storeData1,
    input  logic                excIn1,
    output logic                go0,
    output logic                we0,
    output strobeT              sel0,
    output logic [AdrWidth-1:0] adr0,
    output wordT                dat0,
    output logic                go1,
    output logic                we1,
    output strobeT              sel1,
    output logic [AdrWidth-1:0] adr1,
    output wordT                dat1,
    output logic                excM,
    output logic                excLane,
    output excCodeT             excCode,
    output wordT                badVaddr
);

    logic mem0, mem1;                               // Lane holds a load or a store.
    logic misRaw0, misRaw1;
    logic bad0, bad1;                               // Misaligned memory access.
    logic exc0, exc1;                               // Pending exception from upstream.
    logic kill1;

    // kseg0 and kseg1 both map onto the low 512 MB; the rest is unmapped here.
    function automatic wordT toPhys(input wordT va);
        if (va[31:30] == 2'b10) begin
            return {3'b000, va[28:0]};
        end
        return va;
    endfunction

    storeAlign uAlign1 (
        .size       (size1),
        .addrLow    (vaddr1[1:0]),
        .storeData  (storeData1),
        .laneData   (dat1),
        .sel        (sel1),
        .misaligned (misRaw1)
    );

    storeAlign uAlign0 (
        .size       (size0),
        .addrLow    (vaddr0[1:0]),
        .storeData  (storeData0),
        .laneData   (dat0),
        .sel        (sel0),
        .misaligned (misRaw0)
    );

    assign mem1 = laneValid1 && (isLoad1 || isStore1);
    assign mem0 = laneValid0 && (isLoad0 || isStore0);
    assign bad1 = mem1 && misRaw1;                  // Loads follow the store rule.
    assign bad0 = mem0 && misRaw0;
    assign exc1 = laneValid1 && excIn1;
    assign exc0 = laneValid0 && excIn0;

    assign kill1 = exc1 || bad1;                    // Anything wrong on lane 1 kills lane 0.

    assign go1 = mem1 && !kill1;
    assign go0 = mem0 && !exc0 && !bad0 && !kill1;
    assign we1 = isStore1;
    assign we0 = isStore0;

    assign adr1 = AdrWidth'(toPhys(vaddr1));
    assign adr0 = AdrWidth'(toPhys(vaddr0));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Exception resolution in program order
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        excM     = 1'b0;
        excLane  = 1'b0;
        excCode  = excNone;
        badVaddr = '0;
        if (exc1) begin
            excM    = 1'b1;                         // Cause is already known upstream.
            excLane = 1'b1;
        end else if (bad1) begin
            excM     = 1'b1;
            excLane  = 1'b1;
            excCode  = isStore1 ? excAdES : excAdEL;
            badVaddr = vaddr1;
        end else if (exc0) begin
            excM = 1'b1;
        end else if (bad0) begin
            excM     = 1'b1;
            excCode  = isStore0 ? excAdES : excAdEL;
            badVaddr = vaddr0;
        end
    end

endmodule

`default_nettype wire

// ==== logic/dbusMaster.sv ====
`timescale 1ns/1ps
`default_nettype none

module dbusMaster import memPkg::*; #(
    parameter int AdrWidth = 29
) (
    input  logic                clk,
    input  logic                rstN,
    input  logic                issue,
    input  logic                go0,
    input  logic                we0,
    input  strobeT              sel0,
    input  logic [AdrWidth-1:0] adr0,
    input  wordT                dat0,
    input  logic                go1,
    input  logic                we1,
    input  strobeT              sel1,
    input  logic [AdrWidth-1:0] adr1,
    input  wordT                dat1,
    input  msizeT               size0,
    input  msizeT               size1,
    input  logic                signExt0,
    input  logic                signExt1,
    input  logic [1:0]          addrLow0,
    input  logic [1:0]          addrLow1,
    input  logic                excMNext,
    input  logic                excLaneNext,
    input  excCodeT             excCodeNext,
    input  wordT                badVaddrNext,
    output logic                cyc,
    output logic                stb,
    output logic                we,
    output strobeT              sel,
    output logic [AdrWidth-3:0] adr,
    output wordT                datW,
    input  wordT                datR,
    input  logic                ack,
    output logic                busy,
    output logic                done,
    output logic                excM,
    output logic                excLane,
    output excCodeT             excCode,
    output wordT                badVaddr,
    output wordT                loadData0,
    output wordT                loadData1
);

    busStateT            state;
    logic                cycQ;
    logic                start;
    logic                laneOne;
    logic                go0Q, we0Q, we1Q;
    strobeT              sel0Q, sel1Q;
    logic [AdrWidth-3:0] adr0Q, adr1Q;
    wordT                dat0Q, dat1Q;
    msizeT               size0Q, size1Q;
    logic                sext0Q, sext1Q;
    logic [1:0]          low0Q, low1Q;
    wordT                loadValue;

    assign start   = issue && (state == busIdle);
    assign laneOne = (state == busLane1);
    assign busy    = (state != busIdle);

    // Request fields are steady for the whole lane state.
    assign cyc  = cycQ;
    assign stb  = cycQ;
    assign we   = laneOne ? we1Q : we0Q;
    assign sel  = laneOne ? sel1Q : sel0Q;
    assign adr  = laneOne ? adr1Q : adr0Q;
    assign datW = laneOne ? dat1Q : dat0Q;

    loadExtend uExtend (
        .size      (laneOne ? size1Q : size0Q),
        .addrLow   (laneOne ? low1Q : low0Q),
        .signExt   (laneOne ? sext1Q : sext0Q),
        .readWord  (datR),
        .loadValue (loadValue)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= busIdle;
            cycQ  <= 1'b0;
            done  <= 1'b0;
            excM  <= 1'b0;
        end else begin
            done <= (state == busDone);
            case (state)
                busIdle: begin
                    if (issue) begin
                        excM <= excMNext;
                        if (go1) begin
                            state <= busLane1;
                        end else if (go0) begin
                            state <= busLane0;
                        end else begin
                            state <= busDone;
                        end
                    end
                end
                busLane1, busLane0: begin
                    if (!cycQ) begin
                        cycQ <= 1'b1;               // Open the cycle one clock in.
                    end else if (ack) begin
                        cycQ  <= 1'b0;
                        state <= (laneOne && go0Q) ? busLane0 : busDone;
                    end
                end
                default: begin
                    state <= busIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            go0Q      <= go0;
            we0Q      <= we0;
            we1Q      <= we1;
            sel0Q     <= sel0;
            sel1Q     <= sel1;
            adr0Q     <= adr0[AdrWidth-1:2];
            adr1Q     <= adr1[AdrWidth-1:2];
            dat0Q     <= dat0;
            dat1Q     <= dat1;
            size0Q    <= size0;
            size1Q    <= size1;
            sext0Q    <= signExt0;
            sext1Q    <= signExt1;
            low0Q     <= addrLow0;
            low1Q     <= addrLow1;
            excLane   <= excLaneNext;
            excCode   <= excCodeNext;
            badVaddr  <= badVaddrNext;
            loadData0 <= '0;                        // Stays zero unless this lane loads.
            loadData1 <= '0;
        end else if (cycQ && ack && !we) begin
            if (laneOne) begin
                loadData1 <= loadValue;
            end else begin
                loadData0 <= loadValue;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/memSubsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module memSubsys import memPkg::*; #(
    parameter int AdrWidth = 29
) (
    input  logic                clk,
    input  logic                rstN,
    input  logic                laneValid0,
    input  logic                isLoad0,
    input  logic                isStore0,
    input  msizeT               size0,
    input  logic                signExt0,
    input  wordT                vaddr0,
    input  wordT                storeData0,
    input  logic                excIn0,
    input  logic                laneValid1,
    input  logic                isLoad1,
    input  logic                isStore1,
    input  msizeT               size1,
    input  logic                signExt1,
    input  wordT                vaddr1,
    input  wordT                storeData1,
    input  logic                excIn1,
    input  logic                issue,
    output logic                busy,
    output logic                done,
    output logic                excM,
    output logic                excLane,
    output excCodeT             excCode,
    output wordT                badVaddr,
    output wordT                loadData0,
    output wordT                loadData1,
    output logic                cyc,
    output logic                stb,
    output logic                we,
    output strobeT              sel,
    output logic [AdrWidth-3:0] adr,
    output wordT                datW,
    input  wordT                datR,
    input  logic                ack
);

    logic                go0, go1;
    logic                we0, we1;
    strobeT              sel0, sel1;
    logic [AdrWidth-1:0] adr0, adr1;
    wordT                dat0, dat1;
    logic                stageExcM;
    logic                stageExcLane;
    excCodeT             stageExcCode;
    wordT                stageBadVaddr;

    memStage #(.AdrWidth(AdrWidth)) uStage (
        .laneValid0 (laneValid0),
        .isLoad0    (isLoad0),
        .isStore0   (isStore0),
        .size0      (size0),
        .vaddr0     (vaddr0),
        .storeData0 (storeData0),
        .excIn0     (excIn0),
        .laneValid1 (laneValid1),
        .isLoad1    (isLoad1),
        .isStore1   (isStore1),
        .size1      (size1),
        .vaddr1     (vaddr1),
        .storeData1 (storeData1),
        .excIn1     (excIn1),
        .go0        (go0),
        .we0        (we0),
        .sel0       (sel0),
        .adr0       (adr0),
        .dat0       (dat0),
        .go1        (go1),
        .we1        (we1),
        .sel1       (sel1),
        .adr1       (adr1),
        .dat1       (dat1),
        .excM       (stageExcM),
        .excLane    (stageExcLane),
        .excCode    (stageExcCode),
        .badVaddr   (stageBadVaddr)
    );

    dbusMaster #(.AdrWidth(AdrWidth)) uMaster (
        .clk          (clk),
        .rstN         (rstN),
        .issue        (issue),
        .go0          (go0),
        .we0          (we0),
        .sel0         (sel0),
        .adr0         (adr0),
        .dat0         (dat0),
        .go1          (go1),
        .we1          (we1),
        .sel1         (sel1),
        .adr1         (adr1),
        .dat1         (dat1),
        .size0        (size0),
        .size1        (size1),
        .signExt0     (signExt0),
        .signExt1     (signExt1),
        .addrLow0     (vaddr0[1:0]),
        .addrLow1     (vaddr1[1:0]),
        .excMNext     (stageExcM),
        .excLaneNext  (stageExcLane),
        .excCodeNext  (stageExcCode),
        .badVaddrNext (stageBadVaddr),
        .cyc          (cyc),
        .stb          (stb),
        .we           (we),
        .sel          (sel),
        .adr          (adr),
        .datW         (datW),
        .datR         (datR),
        .ack          (ack),
        .busy         (busy),
        .done         (done),
        .excM         (excM),
        .excLane      (excLane),
        .excCode      (excCode),
        .badVaddr     (badVaddr),
        .loadData0    (loadData0),
        .loadData1    (loadData1)
    );

endmodule

`default_nettype wire

// ==== test/tbClock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
    parameter int Period      = 8,
    parameter int ResetCycles = 16
) (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #(Period / 2) clk = ~clk;
    end

    initial begin
        rstN = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== test/memSubsys_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module memSubsysChk #(
    parameter int AdrWidth = 29
) (
    input wire logic                clk,
    input wire logic                rstN,
    input wire logic                cyc,
    input wire logic                stb,
    input wire logic                we,
    input wire logic [3:0]          sel,
    input wire logic [AdrWidth-3:0] adr,
    input wire logic [31:0]         datW,
    input wire logic                ack,
    input wire logic                issue,
    input wire logic                busy,
    input wire logic                done
);

    stbNeedsCyc: assert property (@(posedge clk) disable iff (!rstN) stb |-> cyc)
        else $error("stb without cyc");

    // A waiting strobe keeps the whole request steady into the next cycle.
    requestHeld: assert property (@(posedge clk) disable iff (!rstN)
        (stb && !ack) |=> (stb && $stable(adr) && $stable(sel) && $stable(we)
                           && $stable(datW)))
        else $error("Wishbone request changed before ack");

    issueWhenIdle: assert property (@(posedge clk) disable iff (!rstN) issue |-> !busy)
        else $error("issue while busy");

    donePulse: assert property (@(posedge clk) disable iff (!rstN) done |=> !done)
        else $error("done longer than one cycle");

endmodule

`default_nettype wire

// ==== test/memSubsysTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module memSubsysTb import memPkg::*; ();

    localparam int AdrWidth   = 29;
    localparam int PairCycles = 40;                 // Worst case per pair with margin.

    logic                clk, rstN;
    logic                laneValid0, isLoad0, isStore0, signExt0, excIn0;
    logic                laneValid1, isLoad1, isStore1, signExt1, excIn1;
    msizeT               size0, size1;
    wordT                vaddr0, vaddr1, storeData0, storeData1;
    logic                issue, busy, done, excM, excLane;
    excCodeT             excCode;
    wordT                badVaddr, loadData0, loadData1;
    logic                cyc, stb, we;
    strobeT              sel;
    logic [AdrWidth-3:0] adr;
    wordT                datW;
    wordT                datR = '0;
    logic                ack = 1'b0;

    wordT        ram [256];
    logic        pending = 1'b0;
    logic [1:0]  waitLeft = '0;
    logic [31:0] lfsrState = 32'h807d_12f1;
    int          errors = 0;
    int          vecCount = 0;
    string       vecLines[$];

    tbClock uClock (.clk(clk), .rstN(rstN));

    memSubsys #(.AdrWidth(AdrWidth)) DUT (.*);

    bind memSubsys memSubsysChk #(.AdrWidth(AdrWidth)) uChk (
        .clk(clk), .rstN(rstN), .cyc(cyc), .stb(stb), .we(we), .sel(sel), .adr(adr),
        .datW(datW), .ack(ack), .issue(issue), .busy(busy), .done(done)
    );

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Wishbone RAM slave with random wait states
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        for (int i = 0; i < 256; i++) begin
            ram[i] = '0;
        end
    end

    always @(posedge clk) begin
        ack <= 1'b0;
        if (cyc && stb && !ack) begin
            if (!pending) begin
                pending     <= 1'b1;
                waitLeft[0] <= lfsrState[0];        // One step per bit taken.
                lfsrState    = lfsrNext(lfsrState);
                waitLeft[1] <= lfsrState[0];
                lfsrState    = lfsrNext(lfsrState);
            end else if (waitLeft == 2'd0) begin
                pending <= 1'b0;
                ack     <= 1'b1;
                datR    <= ram[adr[7:0]];
                for (int b = 0; b < 4; b++) begin
                    if (we && sel[b]) begin
                        ram[adr[7:0]][8*b +: 8] <= datW[8*b +: 8];
                    end
                end
            end else begin
                waitLeft <= waitLeft - 2'd1;
            end
        end
    end

    task automatic checkValue(input string name, input wordT expected, input wordT actual);
        if (expected !== actual) begin
            $display("** Error: %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // Columns: lane 1 inputs, lane 0 inputs, then the expected results.
    task automatic runPair(input string line, input int idx);
        logic [31:0] f [23];
        int          n;
        int          cycles;
        int          busyLow;
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
            f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21], f[22]);
        if (n != 23) begin
            $display("Vector %0d is malformed and was skipped", idx);
            errors++;
            return;
        end
        while (busy) @(posedge clk);
        laneValid1 <= f[0][0];
        isLoad1    <= f[1][0];
        isStore1   <= f[2][0];
        size1      <= msizeT'(f[3][1:0]);
        signExt1   <= f[4][0];
        vaddr1     <= f[5];
        storeData1 <= f[6];
        excIn1     <= f[7][0];
        laneValid0 <= f[8][0];
        isLoad0    <= f[9][0];
        isStore0   <= f[10][0];
        size0      <= msizeT'(f[11][1:0]);
        signExt0   <= f[12][0];
        vaddr0     <= f[13];
        storeData0 <= f[14];
        excIn0     <= f[15][0];
        issue      <= 1'b1;
        @(posedge clk);
        issue  <= 1'b0;
        cycles = 0;
        busyLow = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (!done && !busy) begin
                busyLow++;                          // Busy covers every cycle up to done.
            end
        end while (!done);
        checkValue($sformatf("vec%0d busy low cycles", idx), 32'd0, wordT'(busyLow));
        checkValue($sformatf("vec%0d excM", idx), f[16], wordT'(excM));
        checkValue($sformatf("vec%0d excLane", idx), f[17], wordT'(excLane));
        checkValue($sformatf("vec%0d excCode", idx), f[18], wordT'(excCode));
        checkValue($sformatf("vec%0d badVaddr", idx), f[19], badVaddr);
        checkValue($sformatf("vec%0d loadData0", idx), f[20], loadData0);
        checkValue($sformatf("vec%0d loadData1", idx), f[21], loadData1);
        if (f[22][0]) begin
            checkValue($sformatf("vec%0d done latency", idx), 32'd2, wordT'(cycles));
        end
    endtask

    initial begin
        int    fd;
        string line;
        laneValid0 = 1'b0;
        isLoad0    = 1'b0;
        isStore0   = 1'b0;
        size0      = sizeByte;
        signExt0   = 1'b0;
        vaddr0     = '0;
        storeData0 = '0;
        excIn0     = 1'b0;
        laneValid1 = 1'b0;
        isLoad1    = 1'b0;
        isStore1   = 1'b0;
        size1      = sizeByte;
        signExt1   = 1'b0;
        vaddr1     = '0;
        storeData1 = '0;
        excIn1     = 1'b0;
        issue      = 1'b0;
        fd = $fopen("test/memVectors.txt", "r");
        if (fd == 0) begin
            $display("The vector file test/memVectors.txt could not be opened");
            $display("Finished with errors");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 8 && line[0] != "#") begin
                    vecLines.push_back(line);
                end
            end
            $fclose(fd);
            if (vecLines.size() == 0) begin
                $display("The vector file holds no vectors");
                errors++;
            end
            vecCount = vecLines.size();
            wait (rstN);
            @(posedge clk);
            foreach (vecLines[i]) begin
                runPair(vecLines[i], i);
            end
            $display("Vectors: %0d  errors: %0d", vecCount, errors);
            if (errors == 0) begin
                $display("Finished with no errors");
            end else begin
                $display("Finished with errors");
            end
            $finish;
        end
    end

    initial begin
        wait (vecCount > 0);
        #((vecCount * PairCycles + 64) * 8);
        $display("Timeout: the DUT did not finish all vectors in time");
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/memVectors.txt ====
# v1 ld1 st1 sz1 sx1 vaddr1 data1 exc1 | v0 ld0 st0 sz0 sx0 vaddr0 data0 exc0 |
# excM excLane excCode badVaddr loadData0 loadData1 twoCycleDone (sizes 0 B, 1 H, 2 W)
1 0 1 2 0 80000010 11223344 0 1 1 0 2 0 80000010 00000000 0 0 0 0 00000000 11223344 00000000 0
1 1 0 2 0 a0000010 00000000 0 0 0 0 0 0 00000000 00000000 0 0 0 0 00000000 00000000 11223344 0
1 0 1 0 0 80000020 000000f0 0 1 0 1 0 0 80000021 000000a5 0 0 0 0 00000000 00000000 00000000 0
1 0 1 0 0 80000022 0000007f 0 1 0 1 0 0 80000023 00000080 0 0 0 0 00000000 00000000 00000000 0
1 1 0 0 1 80000020 00000000 0 1 1 0 0 0 80000020 00000000 0 0 0 0 00000000 000000f0 fffffff0 0
1 1 0 0 1 80000021 00000000 0 1 1 0 0 0 80000021 00000000 0 0 0 0 00000000 000000a5 ffffffa5 0
1 1 0 0 1 80000022 00000000 0 1 1 0 0 1 80000023 00000000 0 0 0 0 00000000 ffffff80 0000007f 0
1 1 0 0 0 80000023 00000000 0 1 1 0 2 0 80000020 00000000 0 0 0 0 00000000 807fa5f0 00000080 0
1 0 1 1 0 80000030 00008001 0 1 0 1 1 0 80000032 00007ffe 0 0 0 0 00000000 00000000 00000000 0
1 1 0 1 1 80000030 00000000 0 1 1 0 1 0 80000030 00000000 0 0 0 0 00000000 00008001 ffff8001 0
1 1 0 1 1 80000032 00000000 0 1 1 0 1 0 80000032 00000000 0 0 0 0 00000000 00007ffe 00007ffe 0
1 0 1 2 0 80000040 cafef00d 0 0 0 0 0 0 00000000 00000000 0 0 0 0 00000000 00000000 00000000 0
0 0 0 0 0 00000000 00000000 0 1 0 1 2 0 80000042 12345678 0 1 0 2 80000042 00000000 00000000 1
1 0 1 1 0 80000041 0000ffff 0 0 0 0 0 0 00000000 00000000 0 1 1 2 80000041 00000000 00000000 1
1 1 0 2 0 80000040 00000000 0 1 1 0 1 1 80000043 00000000 0 1 0 1 80000043 00000000 cafef00d 0
1 1 0 2 0 80000042 00000000 0 1 0 1 2 0 80000041 87654321 0 1 1 1 80000042 00000000 00000000 1
1 1 0 1 0 80000041 00000000 0 1 0 1 2 0 80000040 deadbeef 0 1 1 1 80000041 00000000 00000000 1
1 1 0 2 0 80000040 00000000 0 1 1 0 0 0 80000040 00000000 0 0 0 0 00000000 0000000d cafef00d 0
1 0 1 2 0 80000040 0badf00d 1 1 0 1 2 0 80000044 55555555 0 1 1 0 00000000 00000000 00000000 1
1 0 0 0 0 00000000 00000000 1 1 1 0 2 0 80000040 00000000 0 1 1 0 00000000 00000000 00000000 1
1 0 1 2 0 80000044 66666666 0 1 0 1 2 0 80000040 0badf00d 1 1 0 0 00000000 00000000 00000000 0
1 1 0 2 0 80000040 00000000 0 1 1 0 2 0 a0000044 00000000 0 0 0 0 00000000 66666666 cafef00d 0
1 0 1 2 0 a0000050 89abcdef 0 1 1 0 2 0 80000050 00000000 0 0 0 0 00000000 89abcdef 00000000 0
1 0 1 0 0 a0000051 00000011 0 1 1 0 1 1 80000050 00000000 0 0 0 0 00000000 000011ef 00000000 0
1 1 0 1 0 80000052 00000000 0 1 1 0 1 1 a0000052 00000000 0 0 0 0 00000000 ffff89ab 000089ab 0
1 1 0 2 0 80000060 00000000 0 1 1 0 0 1 80000061 00000000 0 0 0 0 00000000 00000000 00000000 0
0 0 0 0 0 00000000 00000000 0 0 0 0 0 0 00000000 00000000 0 0 0 0 00000000 00000000 00000000 1
1 0 1 1 0 80000062 0000beef 0 1 1 0 2 0 80000060 00000000 0 0 0 0 00000000 beef0000 00000000 0

// ==== vlog.f ====
logic/memPkg.sv
logic/storeAlign.sv
logic/loadExtend.sv
logic/memStage.sv
logic/dbusMaster.sv
logic/memSubsys.sv
test/tbClock.sv
test/memSubsys_chk.sv
test/memSubsysTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = memSubsysTb
FILELIST  = vlog.f
LOG       = sim.log
OBJDIR    = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
